// File: design/uart_pkg.sv
package uart_pkg;

    // Bus geometry
    localparam int unsigned ADDR_W = 4;
    localparam int unsigned DATA_W = 32;

    // Register map
    localparam logic [ADDR_W-1:0] REG_SEND   = 4'd0;
    localparam logic [ADDR_W-1:0] REG_STATUS = 4'd1;
    localparam logic [ADDR_W-1:0] REG_RECV   = 4'd2;

    // Baud timing on clk_bus
    localparam int unsigned OVERSAMPLE   = 16;                      // Ticks per bit
    localparam int unsigned BAUD_DIV     = 4;                       // Clocks per tick
    localparam int unsigned CLKS_PER_BIT = OVERSAMPLE * BAUD_DIV;   // 64 clocks
    localparam int unsigned OS_CNT_W     = $clog2(OVERSAMPLE);
    localparam int unsigned DIV_CNT_W    = $clog2(BAUD_DIV);

    // 8N1 frame is start + 8 data + stop
    localparam int unsigned FRAME_BITS = 10;

    // Status word bit positions
    localparam int unsigned STAT_TX_IDLE   = 0;
    localparam int unsigned STAT_RX_VALID  = 1;
    localparam int unsigned STAT_OVERRUN   = 2;
    localparam int unsigned STAT_FRAME_ERR = 3;

    // One bus access as seen by the register block
    typedef struct packed {
        logic [ADDR_W-1:0] address;
        logic              read;
        logic              write;
        logic [DATA_W-1:0] wdata;
    } bus_req_t;

    // Layout matches the STAT_* positions, tx_idle in bit 0
    typedef struct packed {
        logic frame_err;
        logic overrun;
        logic rx_valid;
        logic tx_idle;
    } uart_status_t;

endpackage

// File: design/uart_regs.sv
module uart_regs import uart_pkg::*; (
    input  logic              clk_bus,
    input  logic              rst_n,
    input  bus_req_t          bus_req_i,
    input  logic              tx_busy_i,
    input  logic              rx_done_i,
    input  logic [7:0]        rx_byte_i,
    input  logic              frame_err_i,
    output logic [DATA_W-1:0] bus_data_o,
    output logic              tx_start_o,
    output logic [7:0]        tx_data_o
);

    logic         wr_send;
    logic         wr_status;
    logic         clr_valid;
    logic         clr_overrun;
    logic         clr_frame;
    logic         valid_eff;
    logic         rx_valid_q;
    logic         overrun_q;
    logic         frame_err_q;
    logic [7:0]   rx_data_q;
    uart_status_t status;

    assign wr_send   = bus_req_i.write && (bus_req_i.address == REG_SEND);
    assign wr_status = bus_req_i.write && (bus_req_i.address == REG_STATUS);

    // Clear-on-write masks
    assign clr_valid   = wr_status && bus_req_i.wdata[STAT_RX_VALID];
    assign clr_overrun = wr_status && bus_req_i.wdata[STAT_OVERRUN];
    assign clr_frame   = wr_status && bus_req_i.wdata[STAT_FRAME_ERR];

    // A byte arriving together with a clear is not an overrun
    assign valid_eff = rx_valid_q && !clr_valid;

    // Started in the same cycle so tx_idle drops at the write edge
    assign tx_start_o = wr_send && !tx_busy_i;     // Busy write is dropped
    assign tx_data_o  = bus_req_i.wdata[7:0];

    assign status.frame_err = frame_err_q;
    assign status.overrun   = overrun_q;
    assign status.rx_valid  = rx_valid_q;
    assign status.tx_idle   = !tx_busy_i;

    always_ff @(posedge clk_bus or negedge rst_n) begin
        if (!rst_n) begin
            rx_valid_q  <= 1'b0;
            overrun_q   <= 1'b0;
            frame_err_q <= 1'b0;
            rx_data_q   <= 8'h00;
        end else begin
            if (clr_valid) begin
                rx_valid_q <= 1'b0;
            end
            if (clr_overrun) begin
                overrun_q <= 1'b0;
            end
            if (clr_frame) begin
                frame_err_q <= 1'b0;
            end
            if (rx_done_i) begin
                if (valid_eff) begin
                    overrun_q <= 1'b1;     // Old byte kept
                end else begin
                    rx_data_q  <= rx_byte_i;
                    rx_valid_q <= 1'b1;
                end
            end
            if (frame_err_i) begin
                frame_err_q <= 1'b1;
            end
        end
    end

    // Registered read data, held until the next read
    always_ff @(posedge clk_bus or negedge rst_n) begin
        if (!rst_n) begin
            bus_data_o <= '0;
        end else if (bus_req_i.read) begin
            case (bus_req_i.address)
                REG_STATUS: bus_data_o <= DATA_W'(status);
                REG_RECV:   bus_data_o <= DATA_W'(rx_data_q);
                default:    bus_data_o <= '0;
            endcase
        end
    end

endmodule

// File: design/uart_baud_gen.sv
module uart_baud_gen import uart_pkg::*; (
    input  logic clk_bus,
    input  logic rst_n,
    output logic os_tick_o,
    output logic bit_tick_o
);

    logic [DIV_CNT_W-1:0] div_cnt_q;
    logic [OS_CNT_W-1:0]  os_cnt_q;
    logic                 div_wrap;

    assign div_wrap = (div_cnt_q == DIV_CNT_W'(BAUD_DIV - 1));

    always_ff @(posedge clk_bus or negedge rst_n) begin
        if (!rst_n) begin
            div_cnt_q  <= '0;
            os_cnt_q   <= '0;
            os_tick_o  <= 1'b0;
            bit_tick_o <= 1'b0;
        end else begin
            div_cnt_q  <= div_wrap ? '0 : div_cnt_q + 1'b1;
            os_tick_o  <= div_wrap;                     // One clock wide
            bit_tick_o <= div_wrap && (os_cnt_q == OS_CNT_W'(OVERSAMPLE - 1));
            if (div_wrap) begin
                os_cnt_q <= os_cnt_q + 1'b1;           // Wraps at OVERSAMPLE
            end
        end
    end

endmodule

// File: design/uart_tx.sv
module uart_tx import uart_pkg::*; (
    input  logic       clk_bus,
    input  logic       rst_n,
    input  logic       bit_tick_i,
    input  logic       tx_start_i,
    input  logic [7:0] tx_data_i,
    output logic       txd_o,
    output logic       tx_busy_o
);

    logic [FRAME_BITS-1:0] frame_q;
    logic [3:0]            bit_cnt_q;
    logic                  busy_q;
    logic                  frame_done;

    assign frame_done = (bit_cnt_q == 4'(FRAME_BITS));
    assign tx_busy_o  = busy_q;

    // Frame shifts out LSB first and refills with idle ones
    always_ff @(posedge clk_bus) begin
        if (tx_start_i && !busy_q) begin
            frame_q <= {1'b1, tx_data_i, 1'b0};        // Stop, data, start
        end else if (busy_q && bit_tick_i) begin
            frame_q <= {1'b1, frame_q[FRAME_BITS-1:1]};
        end
    end

    always_ff @(posedge clk_bus or negedge rst_n) begin
        if (!rst_n) begin
            busy_q    <= 1'b0;
            bit_cnt_q <= '0;
            txd_o     <= 1'b1;                         // Line idles high
        end else if (!busy_q) begin
            if (tx_start_i) begin
                busy_q    <= 1'b1;                     // Wait for next bit tick
                bit_cnt_q <= '0;
            end
        end else if (bit_tick_i) begin
            if (frame_done) begin
                busy_q <= 1'b0;                        // Stop bit served its full period
            end else begin
                txd_o     <= frame_q[0];
                bit_cnt_q <= bit_cnt_q + 1'b1;
            end
        end
    end

endmodule

// File: design/uart_rx.sv
module uart_rx import uart_pkg::*; (
    input  logic       clk_bus,
    input  logic       rst_n,
    input  logic       os_tick_i,
    input  logic       rxd_i,
    output logic       rx_done_o,
    output logic [7:0] rx_byte_o,
    output logic       frame_err_o
);

    typedef enum logic [1:0] {
        RX_IDLE,
        RX_START,
        RX_DATA,
        RX_STOP
    } rx_state_e;

    rx_state_e           state_q;
    logic [1:0]          sync_q;
    logic                rxd_prev_q;
    logic                rxd_s;
    logic                fall;
    logic [OS_CNT_W-1:0] tick_cnt_q;
    logic [2:0]          bit_cnt_q;
    logic                half_bit;
    logic                full_bit;

    assign rxd_s    = sync_q[1];
    assign fall     = rxd_prev_q && !rxd_s;
    assign half_bit = os_tick_i && (tick_cnt_q == OS_CNT_W'(OVERSAMPLE / 2 - 1));
    assign full_bit = os_tick_i && (tick_cnt_q == OS_CNT_W'(OVERSAMPLE - 1));

    always_ff @(posedge clk_bus or negedge rst_n) begin
        if (!rst_n) begin
            sync_q     <= 2'b11;
            rxd_prev_q <= 1'b1;
        end else begin
            sync_q     <= {sync_q[0], rxd_i};          // Two-flop synchronizer
            rxd_prev_q <= rxd_s;
        end
    end

    // Data bits enter at the top, LSB ends up in bit 0
    always_ff @(posedge clk_bus) begin
        if (state_q == RX_DATA && full_bit) begin
            rx_byte_o <= {rxd_s, rx_byte_o[7:1]};
        end
    end

    always_ff @(posedge clk_bus or negedge rst_n) begin
        if (!rst_n) begin
            state_q     <= RX_IDLE;
            tick_cnt_q  <= '0;
            bit_cnt_q   <= '0;
            rx_done_o   <= 1'b0;
            frame_err_o <= 1'b0;
        end else begin
            rx_done_o   <= 1'b0;
            frame_err_o <= 1'b0;
            if (os_tick_i) begin
                tick_cnt_q <= tick_cnt_q + 1'b1;
            end
            case (state_q)
                RX_IDLE: begin
                    tick_cnt_q <= '0;
                    if (fall) begin
                        state_q <= RX_START;
                    end
                end
                RX_START: begin
                    if (half_bit) begin
                        tick_cnt_q <= '0;              // Realign on mid-bit
                        bit_cnt_q  <= '0;
                        state_q    <= rxd_s ? RX_IDLE : RX_DATA;   // Glitch reject
                    end
                end
                RX_DATA: begin
                    if (full_bit) begin
                        bit_cnt_q <= bit_cnt_q + 1'b1;
                        if (bit_cnt_q == 3'd7) begin
                            state_q <= RX_STOP;
                        end
                    end
                end
                default: begin
                    if (full_bit) begin
                        rx_done_o   <= rxd_s;
                        frame_err_o <= !rxd_s;         // Stop bit must be high
                        state_q     <= RX_IDLE;
                    end
                end
            endcase
        end
    end

endmodule

// File: design/uart_top.sv
module uart_top import uart_pkg::*; (
    input  logic              clk_bus,
    input  logic              rst_n,
    input  logic [ADDR_W-1:0] bus_address_i,
    input  logic [DATA_W-1:0] bus_data_i,
    input  logic              bus_read_i,
    input  logic              bus_write_i,
    input  logic              rxd_i,
    output logic [DATA_W-1:0] bus_data_o,
    output logic              txd_o
);

    bus_req_t   bus_req;
    logic       os_tick;
    logic       bit_tick;
    logic       tx_start;
    logic [7:0] tx_data;
    logic       tx_busy;
    logic       rx_done;
    logic [7:0] rx_byte;
    logic       frame_err_p;

    assign bus_req = '{address: bus_address_i, read: bus_read_i,
                       write: bus_write_i, wdata: bus_data_i};

    uart_regs u_regs (
        .clk_bus     (clk_bus),
        .rst_n       (rst_n),
        .bus_req_i   (bus_req),
        .tx_busy_i   (tx_busy),
        .rx_done_i   (rx_done),
        .rx_byte_i   (rx_byte),
        .frame_err_i (frame_err_p),
        .bus_data_o  (bus_data_o),
        .tx_start_o  (tx_start),
        .tx_data_o   (tx_data)
    );

    uart_baud_gen u_baud (
        .clk_bus    (clk_bus),
        .rst_n      (rst_n),
        .os_tick_o  (os_tick),
        .bit_tick_o (bit_tick)
    );

    uart_tx u_tx (
        .clk_bus    (clk_bus),
        .rst_n      (rst_n),
        .bit_tick_i (bit_tick),
        .tx_start_i (tx_start),
        .tx_data_i  (tx_data),
        .txd_o      (txd_o),
        .tx_busy_o  (tx_busy)
    );

    uart_rx u_rx (
        .clk_bus     (clk_bus),
        .rst_n       (rst_n),
        .os_tick_i   (os_tick),
        .rxd_i       (rxd_i),
        .rx_done_o   (rx_done),
        .rx_byte_o   (rx_byte),
        .frame_err_o (frame_err_p)
    );

endmodule

// File: sim/uart_assert.sv
module uart_assert (
    input logic clk_bus,
    input logic rst_n,
    input logic bus_read_i,
    input logic bus_write_i,
    input logic txd_i,
    input logic tx_busy_i,
    input logic rx_done_i,
    input logic frame_err_i
);

    // One bus access per cycle
    bus_one_access: assert property (@(posedge clk_bus) disable iff (!rst_n)
        !(bus_read_i && bus_write_i))
        else $error("bus read and write high in the same cycle");

    txd_idle_high: assert property (@(posedge clk_bus) disable iff (!rst_n)
        !tx_busy_i |-> txd_i)
        else $error("txd low while the transmitter is idle");

    // Stop bit gives either a byte or an error
    rx_result_unique: assert property (@(posedge clk_bus) disable iff (!rst_n)
        !(rx_done_i && frame_err_i))
        else $error("rx_done and frame_err_p pulsed together");

endmodule

bind uart_top uart_assert u_assert (
    .clk_bus     (clk_bus),
    .rst_n       (rst_n),
    .bus_read_i  (bus_read_i),
    .bus_write_i (bus_write_i),
    .txd_i       (txd_o),
    .tx_busy_i   (tx_busy),
    .rx_done_i   (rx_done),
    .frame_err_i (frame_err_p)
);

// File: sim/uart_tb.sv
module uart_tb import uart_pkg::*; ();

    localparam int unsigned CLK_PERIOD = 40;
    localparam int unsigned FRAME_CLKS = FRAME_BITS * CLKS_PER_BIT;
    localparam int unsigned NUM_TESTS  = 6;
    localparam int unsigned TIMEOUT    = NUM_TESTS * 30 * FRAME_CLKS * CLK_PERIOD;

    logic              clk_bus;
    logic              rst_n;
    logic [ADDR_W-1:0] bus_address;
    logic [DATA_W-1:0] bus_wdata;
    logic              bus_read;
    logic              bus_write;
    logic [DATA_W-1:0] bus_rdata;
    logic              txd;
    logic              rxd;
    logic              rxd_drv;
    logic              loopback;
    integer            seed     = 32'h190fcd37;
    logic [7:0]        patterns [8] = '{8'haa, 8'h00, 8'h55, 8'hff, 8'h01, 8'h80, 8'h92, 8'ha7};

    assign rxd = loopback ? txd : rxd_drv;             // Serial loopback for test 2

    uart_top u_dut (
        .clk_bus       (clk_bus),
        .rst_n         (rst_n),
        .bus_address_i (bus_address),
        .bus_data_i    (bus_wdata),
        .bus_read_i    (bus_read),
        .bus_write_i   (bus_write),
        .rxd_i         (rxd),
        .bus_data_o    (bus_rdata),
        .txd_o         (txd)
    );

    task automatic check_eq(input string name, input logic [31:0] actual,
                            input logic [31:0] expected);
        if (actual !== expected) begin
            $display("error at %0t: %s is %h, expected %h", $time, name, actual, expected);
            $display(">>> FAIL");
            $fatal(1, "value mismatch on %s", name);
        end
    endtask

    // Bus tasks start and end just after a falling edge
    task automatic write_reg(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data);
        bus_address = addr;
        bus_wdata   = data;
        bus_write   = 1'b1;
        @(negedge clk_bus);
        bus_write   = 1'b0;
    endtask

    task automatic read_reg(input logic [ADDR_W-1:0] addr, output logic [DATA_W-1:0] data);
        bus_address = addr;
        bus_read    = 1'b1;
        @(negedge clk_bus);
        bus_read    = 1'b0;
        data        = bus_rdata;                       // Registered one cycle later
    endtask

    task automatic poll_status(input int unsigned bit_pos, input logic value);
        logic [DATA_W-1:0] data;
        do begin
            read_reg(REG_STATUS, data);
        end while (data[bit_pos] !== value);
    endtask

    task automatic send_frame(input logic [7:0] data, input logic stop_bit,
                              input int unsigned glitch_clks);
        logic [FRAME_BITS-1:0] frame;
        frame = {stop_bit, data, 1'b0};
        if (glitch_clks != 0) begin
            rxd_drv = 1'b0;                            // Short false start
            repeat (glitch_clks) @(negedge clk_bus);
            rxd_drv = 1'b1;
            repeat (FRAME_CLKS) @(negedge clk_bus);
        end else begin
            for (int unsigned i = 0; i < FRAME_BITS; i++) begin
                rxd_drv = frame[i];
                repeat (CLKS_PER_BIT) @(negedge clk_bus);
            end
            rxd_drv = 1'b1;
        end
    endtask

    task automatic test_reset_state();
        logic [DATA_W-1:0] data;
        check_eq("txd_o", 32'(txd), 32'h1);
        check_eq("bus_data_o", bus_rdata, 32'h0);
        read_reg(REG_STATUS, data);
        check_eq("status", data, 32'h1 << STAT_TX_IDLE);
        read_reg(REG_RECV, data);
        check_eq("recv", data, 32'h0);
    endtask

    task automatic test_loopback();
        logic [DATA_W-1:0] data;
        loopback = 1'b1;
        foreach (patterns[i]) begin
            poll_status(STAT_TX_IDLE, 1'b1);
            write_reg(REG_SEND, 32'(patterns[i]));
            poll_status(STAT_RX_VALID, 1'b1);
            read_reg(REG_RECV, data);
            check_eq("recv", data, 32'(patterns[i]));
            write_reg(REG_STATUS, 32'h1 << STAT_RX_VALID);
            read_reg(REG_STATUS, data);
            check_eq("status flags", 32'(data[STAT_FRAME_ERR:STAT_RX_VALID]), 32'h0);
        end
        poll_status(STAT_TX_IDLE, 1'b1);
        loopback = 1'b0;
    endtask

    task automatic test_tx_timing();
        logic [7:0]            tx_byte;
        logic [FRAME_BITS-1:0] frame;
        logic [DATA_W-1:0]     data;
        tx_byte = 8'h3c;
        frame   = {1'b1, tx_byte, 1'b0};               // Stop, data, start
        poll_status(STAT_TX_IDLE, 1'b1);
        write_reg(REG_SEND, 32'(tx_byte));
        fork
            begin
                @(negedge txd);
                repeat (CLKS_PER_BIT / 2) @(negedge clk_bus);     // Mid start bit
                for (int unsigned i = 0; i < FRAME_BITS; i++) begin
                    if (i != 0) begin
                        repeat (CLKS_PER_BIT) @(negedge clk_bus);
                    end
                    check_eq("txd_o", 32'(txd), 32'(frame[i]));
                end
            end
            begin
                read_reg(REG_STATUS, data);
                check_eq("status.tx_idle", 32'(data[STAT_TX_IDLE]), 32'h0);
                write_reg(REG_SEND, 32'h0000_00c3);    // Arrives while busy
            end
        join
        poll_status(STAT_TX_IDLE, 1'b1);
        repeat (2 * FRAME_CLKS) begin
            @(negedge clk_bus);
            check_eq("txd_o", 32'(txd), 32'h1);        // No second frame
        end
    endtask

    task automatic test_rx_random();
        logic [31:0]       rnd;
        logic [DATA_W-1:0] data;
        for (int unsigned n = 0; n < 8; n++) begin
            rnd = $random(seed);
            send_frame(rnd[7:0], 1'b1, 0);
            poll_status(STAT_RX_VALID, 1'b1);
            read_reg(REG_RECV, data);
            check_eq("recv", data, 32'(rnd[7:0]));
            write_reg(REG_STATUS, 32'h1 << STAT_RX_VALID);
        end
    endtask

    task automatic test_overrun();
        logic [31:0]       first;
        logic [31:0]       second;
        logic [DATA_W-1:0] data;
        first  = $random(seed);
        second = $random(seed);
        send_frame(first[7:0], 1'b1, 0);
        send_frame(second[7:0], 1'b1, 0);
        read_reg(REG_STATUS, data);
        check_eq("status", data, (32'h1 << STAT_TX_IDLE) | (32'h1 << STAT_RX_VALID) |
                                 (32'h1 << STAT_OVERRUN));
        read_reg(REG_RECV, data);
        check_eq("recv", data, 32'(first[7:0]));
        write_reg(REG_STATUS, (32'h1 << STAT_RX_VALID) | (32'h1 << STAT_OVERRUN));
        read_reg(REG_STATUS, data);
        check_eq("status", data, 32'h1 << STAT_TX_IDLE);
    endtask

    task automatic test_rx_errors();
        logic [DATA_W-1:0] data;
        send_frame(8'h5a, 1'b0, 0);                    // Zero stop bit
        read_reg(REG_STATUS, data);
        check_eq("status", data, (32'h1 << STAT_TX_IDLE) | (32'h1 << STAT_FRAME_ERR));
        write_reg(REG_STATUS, 32'h1 << STAT_FRAME_ERR);
        send_frame(8'h00, 1'b1, 4);
        read_reg(REG_STATUS, data);
        check_eq("status", data, 32'h1 << STAT_TX_IDLE);
    endtask

    initial begin
        clk_bus = 1'b0;
        forever #(CLK_PERIOD / 2) clk_bus = ~clk_bus;
    end

    // 30 frame times for each test
    initial begin
        #(TIMEOUT);
        $display("watchdog: the tests did not finish within %0d time units", TIMEOUT);
        $display(">>> FAIL");
        $fatal(1, "timeout");
    end

    initial begin
        rst_n       = 1'b0;
        bus_address = '0;
        bus_wdata   = '0;
        bus_read    = 1'b0;
        bus_write   = 1'b0;
        rxd_drv     = 1'b1;
        loopback    = 1'b0;
        repeat (5) @(posedge clk_bus);
        @(negedge clk_bus);
        rst_n = 1'b1;
        @(negedge clk_bus);
        test_reset_state();
        test_loopback();
        test_tx_timing();
        test_rx_random();
        test_overrun();
        test_rx_errors();
        $display(">>> PASS");
        $finish;
    end

endmodule

// File: verilog.f
design/uart_pkg.sv
design/uart_regs.sv
design/uart_baud_gen.sv
design/uart_tx.sv
design/uart_rx.sv
design/uart_top.sv
sim/uart_assert.sv
sim/uart_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build the UART testbench with Verilator and run it
cd "$(dirname "$0")" \
    && verilator --binary --timing --assert -f verilog.f --top-module uart_tb -o uart_sim \
    && ./obj_dir/uart_sim \
    || { echo "uart simulation failed"; exit 1; }
